//--- src/rat_cfg_pkg.sv
`default_nettype none

package rat_cfg_pkg;

  // port counts
  localparam int NUM_READ = 3;
  localparam int NUM_NEW = 3;
  localparam int NUM_RET = 3;

  // table geometry, 2 tiles of 8 entries cover 16 registers
  localparam int TILE_SIZE = 8;
  localparam int NUM_TILES = 2;

  // fields of an architectural address
  localparam int ADDR_W = 5;
  localparam int ENTRY_W = 3;
  localparam int TILE_BIT = 3;
  localparam int DEP_BIT = 4;
  localparam int SLOT_W = 4;

  // bit 4 set means the low bits name a bundle slot instead of a register
  typedef logic [ADDR_W-1:0] arch_addr_t;

  // entry number within one tile
  typedef logic [ENTRY_W-1:0] entry_idx_t;

  // bundle slot index carried by each new slot
  typedef logic [SLOT_W-1:0] slot_idx_t;

endpackage

`default_nettype wire

//--- src/rat_data_pkg.sv
`default_nettype none

package rat_data_pkg;

  // payload widths
  localparam int TAG_W = 9;
  localparam int FUNIT_W = 10;

  // ROB tag of the newest in-flight writer
  typedef logic [TAG_W-1:0] rob_tag_t;

  // functional unit that produces the value
  typedef logic [FUNIT_W-1:0] funit_t;

  // values held by an entry that has no writer in flight
  localparam rob_tag_t TAG_RESET = {TAG_W{1'b1}};
  localparam funit_t FUNIT_RESET = {1'b0, {(FUNIT_W - 1){1'b1}}};

endpackage

`default_nettype wire

//--- src/rat_entry.sv
`timescale 1ns/1ps
`default_nettype none

module rat_entry #(
  parameter int INDEX = 0
) (
  input  wire                          clk,
  input  wire                          rst,
  input  wire rat_cfg_pkg::entry_idx_t new_addr_low [rat_cfg_pkg::NUM_NEW],
  input  wire                          new_wen [rat_cfg_pkg::NUM_NEW],
  input  wire rat_data_pkg::rob_tag_t  new_tag [rat_cfg_pkg::NUM_NEW],
  input  wire rat_data_pkg::funit_t    new_funit [rat_cfg_pkg::NUM_NEW],
  input  wire rat_data_pkg::rob_tag_t  ret_tag [rat_cfg_pkg::NUM_RET],
  input  wire                          ret_wen [rat_cfg_pkg::NUM_RET],
  input  wire                          retire_all,
  output rat_data_pkg::rob_tag_t       tag,
  output rat_data_pkg::funit_t         funit,
  output logic                         retired
);

  logic [rat_cfg_pkg::NUM_NEW-1:0] new_hit;
  logic [rat_cfg_pkg::NUM_RET-1:0] ret_hit;
  rat_data_pkg::rob_tag_t tag_d;
  rat_data_pkg::funit_t funit_d;

  // slots that rename this register in the current bundle
  always_comb
  begin
    tag_d = tag;
    funit_d = funit;
    for (int s = 0; s < rat_cfg_pkg::NUM_NEW; s++)
    begin
      new_hit[s] = new_wen[s] && (new_addr_low[s] == rat_cfg_pkg::entry_idx_t'(INDEX));
      if (new_hit[s])
      begin
        tag_d = new_tag[s];
        funit_d = new_funit[s];
      end
    end
  end

  // retire ports carrying the tag this entry waits on
  always_comb
  begin
    for (int p = 0; p < rat_cfg_pkg::NUM_RET; p++)
    begin
      ret_hit[p] = ret_wen[p] && (ret_tag[p] == tag);
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tag <= rat_data_pkg::TAG_RESET;
      funit <= rat_data_pkg::FUNIT_RESET;
      retired <= 1'b1;
    end
    else
    begin
      if (|new_hit)
      begin
        tag <= tag_d;
        funit <= funit_d;
      end
      // flush wins, then a new writer beats the retirement of the old one
      if (retire_all)
        retired <= 1'b1;
      else if (|new_hit)
        retired <= 1'b0;
      else if (|ret_hit)
        retired <= 1'b1;
    end
  end

  // the issue logic never renames one register from two slots of a bundle
  a_one_writer: assert property (@(posedge clk) disable iff (rst) $onehot0(new_hit));

endmodule

`default_nettype wire

//--- src/rat_tile.sv
`timescale 1ns/1ps
`default_nettype none

module rat_tile #(
  parameter int TILE = 0
) (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          read_clk_en,
  input  wire rat_cfg_pkg::arch_addr_t new_addr [rat_cfg_pkg::NUM_NEW],
  input  wire                          new_wen [rat_cfg_pkg::NUM_NEW],
  input  wire rat_data_pkg::rob_tag_t  new_tag [rat_cfg_pkg::NUM_NEW],
  input  wire rat_data_pkg::funit_t    new_funit [rat_cfg_pkg::NUM_NEW],
  input  wire rat_data_pkg::rob_tag_t  ret_tag [rat_cfg_pkg::NUM_RET],
  input  wire                          ret_wen [rat_cfg_pkg::NUM_RET],
  input  wire                          retire_all,
  input  wire rat_cfg_pkg::arch_addr_t read_addr_q [rat_cfg_pkg::NUM_READ],
  output rat_data_pkg::rob_tag_t       tile_tag [rat_cfg_pkg::NUM_READ],
  output rat_data_pkg::funit_t         tile_funit [rat_cfg_pkg::NUM_READ],
  output logic                         tile_retired [rat_cfg_pkg::NUM_READ]
);

  rat_cfg_pkg::entry_idx_t new_addr_low [rat_cfg_pkg::NUM_NEW];
  logic new_wen_tile [rat_cfg_pkg::NUM_NEW];

  wire rat_data_pkg::rob_tag_t entry_tag [rat_cfg_pkg::TILE_SIZE];
  wire rat_data_pkg::funit_t entry_funit [rat_cfg_pkg::TILE_SIZE];
  wire entry_retired [rat_cfg_pkg::TILE_SIZE];

  // a slot writes here only if its register lives in this tile
  always_comb
  begin
    for (int s = 0; s < rat_cfg_pkg::NUM_NEW; s++)
    begin
      new_addr_low[s] = new_addr[s][rat_cfg_pkg::ENTRY_W-1:0];
      new_wen_tile[s] = new_wen[s] && read_clk_en &&
                        (new_addr[s][rat_cfg_pkg::TILE_BIT] == 1'(TILE));
    end
  end

  for (genvar i = 0; i < rat_cfg_pkg::TILE_SIZE; i++)
  begin : g_entry
    rat_entry #(
      .INDEX(i)
    ) u_entry (
      .clk(clk),
      .rst(rst),
      .new_addr_low(new_addr_low),
      .new_wen(new_wen_tile),
      .new_tag(new_tag),
      .new_funit(new_funit),
      .ret_tag(ret_tag),
      .ret_wen(ret_wen),
      .retire_all(retire_all),
      .tag(entry_tag[i]),
      .funit(entry_funit[i]),
      .retired(entry_retired[i])
    );
  end

  // per port entry select, the read port picks the tile
  always_comb
  begin
    for (int p = 0; p < rat_cfg_pkg::NUM_READ; p++)
    begin
      tile_tag[p] = entry_tag[read_addr_q[p][rat_cfg_pkg::ENTRY_W-1:0]];
      tile_funit[p] = entry_funit[read_addr_q[p][rat_cfg_pkg::ENTRY_W-1:0]];
      tile_retired[p] = entry_retired[read_addr_q[p][rat_cfg_pkg::ENTRY_W-1:0]];
    end
  end

endmodule

`default_nettype wire

//--- src/rat_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module rat_bypass (
  input  wire rat_cfg_pkg::arch_addr_t read_addr_q,
  input  wire rat_cfg_pkg::slot_idx_t  new_slot_idx [rat_cfg_pkg::NUM_NEW],
  input  wire rat_data_pkg::rob_tag_t  new_tag [rat_cfg_pkg::NUM_NEW],
  input  wire rat_data_pkg::funit_t    new_funit [rat_cfg_pkg::NUM_NEW],
  output rat_data_pkg::rob_tag_t       dep_tag,
  output rat_data_pkg::funit_t         dep_funit,
  output logic                         is_dep
);

  rat_cfg_pkg::slot_idx_t want_slot;

  assign want_slot = read_addr_q[rat_cfg_pkg::SLOT_W-1:0];
  assign is_dep = read_addr_q[rat_cfg_pkg::DEP_BIT];

  // walk the slots downward so the lowest matching slot is kept
  always_comb
  begin
    dep_tag = '0;
    dep_funit = '0;
    for (int s = rat_cfg_pkg::NUM_NEW - 1; s >= 0; s--)
    begin
      if (new_slot_idx[s] == want_slot)
      begin
        dep_tag = new_tag[s];
        dep_funit = new_funit[s];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/rat_read_port.sv
`timescale 1ns/1ps
`default_nettype none

module rat_read_port (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          read_clk_en,
  input  wire rat_cfg_pkg::arch_addr_t read_addr,
  output rat_cfg_pkg::arch_addr_t      read_addr_q,
  input  wire rat_data_pkg::rob_tag_t  tile_tag [rat_cfg_pkg::NUM_TILES],
  input  wire rat_data_pkg::funit_t    tile_funit [rat_cfg_pkg::NUM_TILES],
  input  wire                          tile_retired [rat_cfg_pkg::NUM_TILES],
  input  wire rat_cfg_pkg::slot_idx_t  new_slot_idx [rat_cfg_pkg::NUM_NEW],
  input  wire rat_data_pkg::rob_tag_t  new_tag [rat_cfg_pkg::NUM_NEW],
  input  wire rat_data_pkg::funit_t    new_funit [rat_cfg_pkg::NUM_NEW],
  output rat_data_pkg::rob_tag_t       read_tag,
  output rat_data_pkg::funit_t         read_funit,
  output logic                         read_retired,
  output logic                         read_is_dep
);

  rat_data_pkg::rob_tag_t dep_tag;
  rat_data_pkg::funit_t dep_funit;
  logic is_dep;
  logic tile_sel;

  // held while the clock enable is low so the port keeps tracking one register
  always_ff @(posedge clk)
  begin
    if (rst)
      read_addr_q <= '0;
    else if (read_clk_en)
      read_addr_q <= read_addr;
  end

  rat_bypass u_bypass (
    .read_addr_q(read_addr_q),
    .new_slot_idx(new_slot_idx),
    .new_tag(new_tag),
    .new_funit(new_funit),
    .dep_tag(dep_tag),
    .dep_funit(dep_funit),
    .is_dep(is_dep)
  );

  assign tile_sel = read_addr_q[rat_cfg_pkg::TILE_BIT];
  assign read_is_dep = is_dep;

  // a producer in the same bundle has not even issued, so it is never retired
  always_comb
  begin
    if (is_dep)
    begin
      read_tag = dep_tag;
      read_funit = dep_funit;
      read_retired = 1'b0;
    end
    else
    begin
      read_tag = tile_tag[tile_sel];
      read_funit = tile_funit[tile_sel];
      read_retired = tile_retired[tile_sel];
    end
  end

  // a sampled address must be fully driven
  a_addr_known: assert property (@(posedge clk) disable iff (rst)
    read_clk_en |-> !$isunknown(read_addr));

endmodule

`default_nettype wire

//--- src/rat_top.sv
`timescale 1ns/1ps
`default_nettype none

module rat_top (
  input  wire                          clk,
  input  wire                          rst,
  input  wire                          read_clk_en,
  input  wire rat_cfg_pkg::arch_addr_t read_addr [rat_cfg_pkg::NUM_READ],
  input  wire rat_cfg_pkg::arch_addr_t new_addr [rat_cfg_pkg::NUM_NEW],
  input  wire                          new_wen [rat_cfg_pkg::NUM_NEW],
  input  wire rat_data_pkg::rob_tag_t  new_tag [rat_cfg_pkg::NUM_NEW],
  input  wire rat_data_pkg::funit_t    new_funit [rat_cfg_pkg::NUM_NEW],
  input  wire rat_cfg_pkg::slot_idx_t  new_slot_idx [rat_cfg_pkg::NUM_NEW],
  input  wire rat_data_pkg::rob_tag_t  ret_tag [rat_cfg_pkg::NUM_RET],
  input  wire                          ret_wen [rat_cfg_pkg::NUM_RET],
  input  wire                          retire_all,
  output wire rat_data_pkg::rob_tag_t  read_tag [rat_cfg_pkg::NUM_READ],
  output wire rat_data_pkg::funit_t    read_funit [rat_cfg_pkg::NUM_READ],
  output wire                          read_retired [rat_cfg_pkg::NUM_READ],
  output wire                          read_is_dep [rat_cfg_pkg::NUM_READ]
);

  // registered addresses fan out from the read ports to every tile
  wire rat_cfg_pkg::arch_addr_t read_addr_q [rat_cfg_pkg::NUM_READ];

  // tile results, indexed tile first and port second
  wire rat_data_pkg::rob_tag_t tile_tag [rat_cfg_pkg::NUM_TILES][rat_cfg_pkg::NUM_READ];
  wire rat_data_pkg::funit_t tile_funit [rat_cfg_pkg::NUM_TILES][rat_cfg_pkg::NUM_READ];
  wire tile_retired [rat_cfg_pkg::NUM_TILES][rat_cfg_pkg::NUM_READ];

  for (genvar t = 0; t < rat_cfg_pkg::NUM_TILES; t++)
  begin : g_tile
    rat_tile #(
      .TILE(t)
    ) u_tile (
      .clk(clk),
      .rst(rst),
      .read_clk_en(read_clk_en),
      .new_addr(new_addr),
      .new_wen(new_wen),
      .new_tag(new_tag),
      .new_funit(new_funit),
      .ret_tag(ret_tag),
      .ret_wen(ret_wen),
      .retire_all(retire_all),
      .read_addr_q(read_addr_q),
      .tile_tag(tile_tag[t]),
      .tile_funit(tile_funit[t]),
      .tile_retired(tile_retired[t])
    );
  end

  for (genvar p = 0; p < rat_cfg_pkg::NUM_READ; p++)
  begin : g_port
    wire rat_data_pkg::rob_tag_t port_tag [rat_cfg_pkg::NUM_TILES];
    wire rat_data_pkg::funit_t port_funit [rat_cfg_pkg::NUM_TILES];
    wire port_retired [rat_cfg_pkg::NUM_TILES];

    // turn the tile-major results around for this port
    for (genvar t = 0; t < rat_cfg_pkg::NUM_TILES; t++)
    begin : g_pick
      assign port_tag[t] = tile_tag[t][p];
      assign port_funit[t] = tile_funit[t][p];
      assign port_retired[t] = tile_retired[t][p];
    end

    rat_read_port u_port (
      .clk(clk),
      .rst(rst),
      .read_clk_en(read_clk_en),
      .read_addr(read_addr[p]),
      .read_addr_q(read_addr_q[p]),
      .tile_tag(port_tag),
      .tile_funit(port_funit),
      .tile_retired(port_retired),
      .new_slot_idx(new_slot_idx),
      .new_tag(new_tag),
      .new_funit(new_funit),
      .read_tag(read_tag[p]),
      .read_funit(read_funit[p]),
      .read_retired(read_retired[p]),
      .read_is_dep(read_is_dep[p])
    );
  end

endmodule

`default_nettype wire

//--- test/rat_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rat_tb;

  localparam int CLK_PERIOD = 20;
  localparam int NUM_FIELDS = 31;

  logic clk;
  logic rst;
  logic read_clk_en;
  rat_cfg_pkg::arch_addr_t read_addr [rat_cfg_pkg::NUM_READ];
  rat_cfg_pkg::arch_addr_t new_addr [rat_cfg_pkg::NUM_NEW];
  logic new_wen [rat_cfg_pkg::NUM_NEW];
  rat_data_pkg::rob_tag_t new_tag [rat_cfg_pkg::NUM_NEW];
  rat_data_pkg::funit_t new_funit [rat_cfg_pkg::NUM_NEW];
  rat_cfg_pkg::slot_idx_t new_slot_idx [rat_cfg_pkg::NUM_NEW];
  rat_data_pkg::rob_tag_t ret_tag [rat_cfg_pkg::NUM_RET];
  logic ret_wen [rat_cfg_pkg::NUM_RET];
  logic retire_all;

  wire rat_data_pkg::rob_tag_t read_tag [rat_cfg_pkg::NUM_READ];
  wire rat_data_pkg::funit_t read_funit [rat_cfg_pkg::NUM_READ];
  wire read_retired [rat_cfg_pkg::NUM_READ];
  wire read_is_dep [rat_cfg_pkg::NUM_READ];

  // fields of the vector being applied, in stim file column order
  logic [31:0] fields [NUM_FIELDS];
  string vectors [$];
  bit stim_loaded;
  int errors;
  int checks;

  rat_top u_dut (
    .clk(clk),
    .rst(rst),
    .read_clk_en(read_clk_en),
    .read_addr(read_addr),
    .new_addr(new_addr),
    .new_wen(new_wen),
    .new_tag(new_tag),
    .new_funit(new_funit),
    .new_slot_idx(new_slot_idx),
    .ret_tag(ret_tag),
    .ret_wen(ret_wen),
    .retire_all(retire_all),
    .read_tag(read_tag),
    .read_funit(read_funit),
    .read_retired(read_retired),
    .read_is_dep(read_is_dep)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(CLK_PERIOD / 2) clk = ~clk;
  end

  // split a text line into hex fields, returns how many were found
  task automatic parse_line(input string line, output int count);
    string tok;
    byte c;
    int start;
    bit sep;
    count = 0;
    start = -1;
    for (int i = 0; i <= line.len(); i++)
    begin
      if (i == line.len())
        sep = 1'b1;
      else
      begin
        c = line.getc(i);
        sep = (c == " " || c == "\t" || c == "\n" || c == "\r");
      end
      if (sep)
      begin
        if (start >= 0)
        begin
          tok = line.substr(start, i - 1);
          if (count < NUM_FIELDS)
            fields[count] = tok.atohex();
          count++;
          start = -1;
        end
      end
      else if (start < 0)
        start = i;
    end
  endtask

  task automatic load_stim();
    int fd;
    int count;
    string line;
    fd = $fopen("test/rat_stim.txt", "r");
    if (fd == 0)
    begin
      $display("could not open the stim file test/rat_stim.txt");
      errors++;
    end
    else
    begin
      while ($fgets(line, fd) > 0)
      begin
        parse_line(line, count);
        // comment and blank lines carry no vector
        if (line.getc(0) != "#" && count > 0)
          vectors.push_back(line);
      end
      $fclose(fd);
      if (vectors.size() == 0)
      begin
        $display("the stim file holds no vectors");
        errors++;
      end
    end
  endtask

  task automatic apply_vector();
    read_clk_en = fields[0][0];
    for (int p = 0; p < rat_cfg_pkg::NUM_READ; p++)
      read_addr[p] = rat_cfg_pkg::arch_addr_t'(fields[1 + p]);
    for (int s = 0; s < rat_cfg_pkg::NUM_NEW; s++)
    begin
      new_wen[s] = fields[4][s];
      new_addr[s] = rat_cfg_pkg::arch_addr_t'(fields[5 + s]);
      new_tag[s] = rat_data_pkg::rob_tag_t'(fields[8 + s]);
      new_funit[s] = rat_data_pkg::funit_t'(fields[11 + s]);
      new_slot_idx[s] = rat_cfg_pkg::slot_idx_t'(fields[14 + s]);
    end
    for (int r = 0; r < rat_cfg_pkg::NUM_RET; r++)
    begin
      ret_wen[r] = fields[17][r];
      ret_tag[r] = rat_data_pkg::rob_tag_t'(fields[18 + r]);
    end
    retire_all = fields[21][0];
  endtask

  task automatic check_outputs(input int vec_no);
    rat_data_pkg::rob_tag_t exp_tag;
    rat_data_pkg::funit_t exp_funit;
    logic exp_retired;
    logic exp_dep;
    for (int p = 0; p < rat_cfg_pkg::NUM_READ; p++)
    begin
      exp_tag = rat_data_pkg::rob_tag_t'(fields[22 + 3 * p]);
      exp_funit = rat_data_pkg::funit_t'(fields[23 + 3 * p]);
      exp_retired = fields[24 + 3 * p][1];
      exp_dep = fields[24 + 3 * p][0];
      if (read_tag[p] !== exp_tag)
      begin
        $display("[FAIL] vector %0d read_tag[%0d] expected %h got %h",
                 vec_no, p, exp_tag, read_tag[p]);
        errors++;
      end
      if (read_funit[p] !== exp_funit)
      begin
        $display("[FAIL] vector %0d read_funit[%0d] expected %h got %h",
                 vec_no, p, exp_funit, read_funit[p]);
        errors++;
      end
      if (read_retired[p] !== exp_retired)
      begin
        $display("[FAIL] vector %0d read_retired[%0d] expected %h got %h",
                 vec_no, p, exp_retired, read_retired[p]);
        errors++;
      end
      if (read_is_dep[p] !== exp_dep)
      begin
        $display("[FAIL] vector %0d read_is_dep[%0d] expected %h got %h",
                 vec_no, p, exp_dep, read_is_dep[p]);
        errors++;
      end
      checks += 4;
    end
  endtask

  initial
  begin
    int count;
    rst = 1'b1;
    read_clk_en = 1'b0;
    retire_all = 1'b0;
    for (int i = 0; i < rat_cfg_pkg::NUM_READ; i++)
      read_addr[i] = '0;
    for (int i = 0; i < rat_cfg_pkg::NUM_NEW; i++)
    begin
      new_addr[i] = '0;
      new_wen[i] = 1'b0;
      new_tag[i] = '0;
      new_funit[i] = '0;
      new_slot_idx[i] = '0;
    end
    for (int i = 0; i < rat_cfg_pkg::NUM_RET; i++)
    begin
      ret_tag[i] = '0;
      ret_wen[i] = 1'b0;
    end
    load_stim();
    stim_loaded = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // apply on the falling edge, compare one ns before the rising edge
    for (int v = 0; v < vectors.size(); v++)
    begin
      parse_line(vectors[v], count);
      if (count != NUM_FIELDS)
      begin
        $display("stim vector %0d has %0d fields instead of %0d", v + 1, count, NUM_FIELDS);
        errors++;
      end
      else
      begin
        apply_vector();
        #(CLK_PERIOD / 2 - 1);
        check_outputs(v + 1);
      end
      @(negedge clk);
    end
    $display("%0d vectors, %0d checks, %0d errors", vectors.size(), checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

  // watchdog sized from the number of vectors
  initial
  begin
    wait (stim_loaded);
    repeat (20 * vectors.size() + 100) @(posedge clk);
    $display("timeout, the vectors did not finish in the time allowed");
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
src/rat_cfg_pkg.sv
src/rat_data_pkg.sv
src/rat_entry.sv
src/rat_tile.sv
src/rat_bypass.sv
src/rat_read_port.sv
src/rat_top.sv
test/rat_tb.sv

//--- Bender.yml
package:
  name: rat

sources:
  - files:
      - src/rat_cfg_pkg.sv
      - src/rat_data_pkg.sv
      - src/rat_entry.sv
      - src/rat_tile.sv
      - src/rat_bypass.sv
      - src/rat_read_port.sv
      - src/rat_top.sv
  - target: test
    files:
      - test/rat_tb.sv

//--- test/rat_stim.txt
# en ra0 ra1 ra2 | wen_mask na0 na1 na2 nt0 nt1 nt2 nf0 nf1 nf2 ns0 ns1 ns2 | ret_mask rt0 rt1 rt2
# retire_all | then per read port: tag funit flags, flags = {retired, is_dep}, all hex
# expected outputs are those seen just before the rising edge that samples the same line
1 00 09 0f 0 00 00 00 000 000 000 000 000 000 0 1 2 0 000 000 000 0 1ff 1ff 2 1ff 1ff 2 1ff 1ff 2
1 03 08 05 7 03 08 00 011 022 033 004 010 200 0 1 2 0 000 000 000 0 1ff 1ff 2 1ff 1ff 2 1ff 1ff 2
1 00 03 08 0 00 00 00 000 000 000 000 000 000 0 1 2 0 000 000 000 0 011 004 0 022 010 0 1ff 1ff 2
1 03 08 00 1 00 00 00 044 000 000 005 000 000 0 1 2 3 022 033 000 0 033 200 0 011 004 0 022 010 0
1 03 08 00 0 00 00 00 000 000 000 000 000 000 0 1 2 0 000 000 000 0 011 004 0 022 010 2 044 005 0
1 03 08 00 0 00 00 00 000 000 000 000 000 000 0 1 2 0 000 000 000 1 011 004 0 022 010 2 044 005 0
1 03 08 00 0 00 00 00 000 000 000 000 000 000 0 1 2 0 000 000 000 0 011 004 2 022 010 2 044 005 2
1 11 03 10 0 00 00 00 000 000 000 000 000 000 0 1 2 0 000 000 000 0 011 004 2 022 010 2 044 005 2
1 11 03 10 7 01 02 0c 055 066 077 021 042 084 0 1 2 0 000 000 000 0 066 042 1 011 004 2 055 021 1
1 13 01 0c 0 00 00 00 0a1 0a2 0a3 0b1 0b2 0b3 3 3 5 0 000 000 000 0 000 000 1 011 004 2 000 000 1
0 02 02 02 7 03 08 00 0a1 0a2 0a3 0b1 0b2 0b3 3 3 5 0 000 000 000 0 0a1 0b1 1 055 021 0 077 084 0
0 02 02 02 0 00 00 00 0a1 0a2 0a3 0b1 0b2 0b3 3 3 5 1 055 000 000 0 0a1 0b1 1 055 021 0 077 084 0
0 02 02 02 0 00 00 00 000 000 000 000 000 000 0 1 2 0 000 000 000 0 000 000 1 055 021 2 077 084 0
1 03 08 00 0 00 00 00 000 000 000 000 000 000 0 1 2 0 000 000 000 0 000 000 1 055 021 2 077 084 0
1 02 0d 09 0 00 00 00 000 000 000 000 000 000 0 1 2 0 000 000 000 0 011 004 2 022 010 2 044 005 2
1 00 00 00 0 00 00 00 000 000 000 000 000 000 0 1 2 0 000 000 000 0 066 042 0 1ff 1ff 2 1ff 1ff 2
1 09 0c 02 1 09 00 00 1a5 000 000 3ff 000 000 0 1 2 0 000 000 000 1 044 005 2 044 005 2 044 005 2
1 09 0c 02 0 00 00 00 000 000 000 000 000 000 0 1 2 0 000 000 000 0 1a5 3ff 2 077 084 2 066 042 2
1 00 00 00 3 0f 07 00 123 0ab 000 321 0cd 000 0 1 2 0 000 000 000 0 1a5 3ff 2 077 084 2 066 042 2
1 0f 07 00 0 00 00 00 000 000 000 000 000 000 0 1 2 0 000 000 000 0 044 005 2 044 005 2 044 005 2
1 00 00 00 0 00 00 00 000 000 000 000 000 000 0 1 2 0 000 000 000 0 123 321 0 0ab 0cd 0 044 005 2
